// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = decodeExecTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== common/cpuPkg.sv ====
`include "cpu_params.svh"

package cpuPkg;

    typedef logic [`DATA_WIDTH-1:0] word;
    typedef logic [4:0] regIdx;
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // Instruction word split along the R-format boundaries
    typedef struct packed {
        funct7T funct7;
        regIdx  rs2;
        regIdx  rs1;
        funct3T funct3;
        regIdx  rd;
        opcodeT opcode;
    } instFields;

    typedef enum logic [5:0] {
        opNop,
        opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi,
        opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu,
        opXor, opSrl, opSra, opOr, opAnd
    } opEnum;

    typedef struct packed {
        word         pc;
        logic [31:0] inst;
    } instRec;

    typedef struct packed {
        opEnum op;
        regIdx rd;
        regIdx rs1;
        regIdx rs2;
        word   imm;
    } decodedRec;

    typedef struct packed {
        word   pc;
        opEnum op;
        regIdx rd;
        logic  wbEn;
        word   wbData;
        word   nextPc;
        word   memAddr;
        word   storeData;
        logic  taken;
    } commitRec;

endpackage

// ==== common/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_WIDTH  32
`define REG_COUNT   32
`define QUEUE_DEPTH 4

`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111
`define OPCODE_BR     7'b1100011
`define OPCODE_L      7'b0000011
`define OPCODE_S      7'b0100011
`define OPCODE_ARITHI 7'b0010011
`define OPCODE_ARITH  7'b0110011

// ALU funct3 shared by register and immediate forms
`define FUNC3_ADD  3'b000
`define FUNC3_SLL  3'b001
`define FUNC3_SLT  3'b010
`define FUNC3_SLTU 3'b011
`define FUNC3_XOR  3'b100
`define FUNC3_SR   3'b101
`define FUNC3_OR   3'b110
`define FUNC3_AND  3'b111

// Load/store access widths
`define FUNC3_B  3'b000
`define FUNC3_H  3'b001
`define FUNC3_W  3'b010
`define FUNC3_BU 3'b100
`define FUNC3_HU 3'b101

`define FUNC3_BEQ  3'b000
`define FUNC3_BNE  3'b001
`define FUNC3_BLT  3'b100
`define FUNC3_BGE  3'b101
`define FUNC3_BLTU 3'b110
`define FUNC3_BGEU 3'b111

`define FUNC7_SPEC 7'b0100000 // SUB and SRA/SRAI

`endif

// ==== exec/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module decoder (
    input  logic [31:0]   inst,
    output cpuPkg::opEnum op,
    output cpuPkg::regIdx rd,
    output cpuPkg::regIdx rs1,
    output cpuPkg::regIdx rs2,
    output logic [31:0]   imm
);

    cpuPkg::instFields f;
    logic [31:0]       iImm;
    logic [31:0]       sImm;
    logic [31:0]       bImm;
    logic [31:0]       jImm;
    logic [31:0]       shamt;

    assign f     = inst;
    assign iImm  = {{20{inst[31]}}, inst[31:20]};
    assign sImm  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign bImm  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign jImm  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign shamt = {27'b0, inst[24:20]};

    always_comb begin
        op  = cpuPkg::opNop;
        rd  = f.rd;
        rs1 = f.rs1;
        rs2 = f.rs2;
        imm = '0;
        case (f.opcode)
            `OPCODE_LUI: begin
                op  = cpuPkg::opLui;
                imm = {inst[31:12], 12'b0};
            end
            `OPCODE_AUIPC: begin
                op  = cpuPkg::opAuipc;
                imm = {inst[31:12], 12'b0};
            end
            `OPCODE_JAL: begin
                op  = cpuPkg::opJal;
                imm = jImm;
            end
            `OPCODE_JALR: begin
                op  = cpuPkg::opJalr;
                imm = iImm;
            end
            `OPCODE_L: begin
                imm = iImm;
                case (f.funct3)
                    `FUNC3_B:  op = cpuPkg::opLb;
                    `FUNC3_H:  op = cpuPkg::opLh;
                    `FUNC3_W:  op = cpuPkg::opLw;
                    `FUNC3_BU: op = cpuPkg::opLbu;
                    `FUNC3_HU: op = cpuPkg::opLhu;
                    default:   op = cpuPkg::opNop;
                endcase
            end
            `OPCODE_ARITHI: begin
                imm = iImm;
                case (f.funct3)
                    `FUNC3_ADD:  op = cpuPkg::opAddi;
                    `FUNC3_SLT:  op = cpuPkg::opSlti;
                    `FUNC3_SLTU: op = cpuPkg::opSltiu;
                    `FUNC3_XOR:  op = cpuPkg::opXori;
                    `FUNC3_OR:   op = cpuPkg::opOri;
                    `FUNC3_AND:  op = cpuPkg::opAndi;
                    `FUNC3_SLL: begin
                        op  = cpuPkg::opSlli;
                        imm = shamt;
                    end
                    default: begin
                        if (f.funct7 == `FUNC7_SPEC) begin
                            op = cpuPkg::opSrai;
                        end else begin
                            op = cpuPkg::opSrli;
                        end
                        imm = shamt; // Drop funct7 bits of the I-immediate
                    end
                endcase
            end
            `OPCODE_BR: begin
                rd  = '0; // No destination
                imm = bImm;
                case (f.funct3)
                    `FUNC3_BEQ:  op = cpuPkg::opBeq;
                    `FUNC3_BNE:  op = cpuPkg::opBne;
                    `FUNC3_BLT:  op = cpuPkg::opBlt;
                    `FUNC3_BGE:  op = cpuPkg::opBge;
                    `FUNC3_BLTU: op = cpuPkg::opBltu;
                    `FUNC3_BGEU: op = cpuPkg::opBgeu;
                    default:     op = cpuPkg::opNop;
                endcase
            end
            `OPCODE_S: begin
                rd  = '0;
                imm = sImm;
                case (f.funct3)
                    `FUNC3_B: op = cpuPkg::opSb;
                    `FUNC3_H: op = cpuPkg::opSh;
                    `FUNC3_W: op = cpuPkg::opSw;
                    default:  op = cpuPkg::opNop;
                endcase
            end
            `OPCODE_ARITH: begin
                if (f.funct3 == `FUNC3_ADD && f.funct7 == `FUNC7_SPEC) begin
                    op = cpuPkg::opSub;
                end else if (f.funct3 == `FUNC3_SR && f.funct7 == `FUNC7_SPEC) begin
                    op = cpuPkg::opSra;
                end else begin
                    case (f.funct3)
                        `FUNC3_ADD:  op = cpuPkg::opAdd;
                        `FUNC3_SLL:  op = cpuPkg::opSll;
                        `FUNC3_SLT:  op = cpuPkg::opSlt;
                        `FUNC3_SLTU: op = cpuPkg::opSltu;
                        `FUNC3_XOR:  op = cpuPkg::opXor;
                        `FUNC3_SR:   op = cpuPkg::opSrl;
                        `FUNC3_OR:   op = cpuPkg::opOr;
                        default:     op = cpuPkg::opAnd;
                    endcase
                end
            end
            default: op = cpuPkg::opNop;
        endcase
        if (op == cpuPkg::opNop) begin
            imm = '0; // Also covers bad funct3 inside a known opcode
        end
    end

endmodule

// ==== exec/execUnit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module execUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  cpuPkg::instRec   inData,
    output logic             inReady,
    output logic             outValid,
    output cpuPkg::commitRec outData,
    input  logic             outReady
);

    cpuPkg::decodedRec dec;
    cpuPkg::word       rs1Val;
    cpuPkg::word       rs2Val;
    cpuPkg::word       opB;
    cpuPkg::word       aluRes;
    cpuPkg::word       pcPlus4;
    cpuPkg::word       pcImm;
    cpuPkg::word       addrSum;
    logic              isAlu;
    logic              brTaken;
    logic              fire;
    logic              wrEn;

    decoder dec0 (
        .inst (inData.inst),
        .op   (dec.op),
        .rd   (dec.rd),
        .rs1  (dec.rs1),
        .rs2  (dec.rs2),
        .imm  (dec.imm)
    );

    regFile rf0 (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (dec.rs1),
        .rdIdxB  (dec.rs2),
        .rdDataA (rs1Val),
        .rdDataB (rs2Val),
        .wrEn    (wrEn),
        .wrIdx   (outData.rd),
        .wrData  (outData.wbData)
    );

    assign inReady  = outReady; // Head leaves only when its record is taken
    assign outValid = inValid;
    assign fire     = inValid && outReady;
    assign wrEn     = fire && outData.wbEn && (outData.rd != '0);

    assign opB     = (inData.inst[6:0] == `OPCODE_ARITHI) ? dec.imm : rs2Val;
    assign pcPlus4 = inData.pc + 32'd4;
    assign pcImm   = inData.pc + dec.imm; // AUIPC, JAL and branch target
    assign addrSum = rs1Val + dec.imm;

    always_comb begin
        isAlu  = 1'b1;
        aluRes = '0;
        case (dec.op)
            cpuPkg::opAdd, cpuPkg::opAddi:   aluRes = rs1Val + opB;
            cpuPkg::opSub:                   aluRes = rs1Val - opB;
            cpuPkg::opSlt, cpuPkg::opSlti:   aluRes = cpuPkg::word'($signed(rs1Val) < $signed(opB));
            cpuPkg::opSltu, cpuPkg::opSltiu: aluRes = cpuPkg::word'(rs1Val < opB);
            cpuPkg::opXor, cpuPkg::opXori:   aluRes = rs1Val ^ opB;
            cpuPkg::opOr, cpuPkg::opOri:     aluRes = rs1Val | opB;
            cpuPkg::opAnd, cpuPkg::opAndi:   aluRes = rs1Val & opB;
            cpuPkg::opSll, cpuPkg::opSlli:   aluRes = rs1Val << opB[4:0];
            cpuPkg::opSrl, cpuPkg::opSrli:   aluRes = rs1Val >> opB[4:0];
            cpuPkg::opSra, cpuPkg::opSrai:   aluRes = $signed(rs1Val) >>> opB[4:0];
            default:                         isAlu = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op)
            cpuPkg::opBeq:  brTaken = (rs1Val == rs2Val);
            cpuPkg::opBne:  brTaken = (rs1Val != rs2Val);
            cpuPkg::opBlt:  brTaken = ($signed(rs1Val) < $signed(rs2Val));
            cpuPkg::opBge:  brTaken = ($signed(rs1Val) >= $signed(rs2Val));
            cpuPkg::opBltu: brTaken = (rs1Val < rs2Val);
            cpuPkg::opBgeu: brTaken = (rs1Val >= rs2Val);
            default:        brTaken = 1'b0;
        endcase
    end

    always_comb begin
        outData        = '0;
        outData.pc     = inData.pc;
        outData.op     = dec.op;
        outData.rd     = dec.rd;
        outData.nextPc = pcPlus4;
        case (dec.op)
            cpuPkg::opLui: begin
                outData.wbEn   = 1'b1;
                outData.wbData = dec.imm;
            end
            cpuPkg::opAuipc: begin
                outData.wbEn   = 1'b1;
                outData.wbData = pcImm;
            end
            cpuPkg::opJal: begin
                outData.wbEn   = 1'b1;
                outData.wbData = pcPlus4; // Link
                outData.taken  = 1'b1;
                outData.nextPc = pcImm;
            end
            cpuPkg::opJalr: begin
                outData.wbEn   = 1'b1;
                outData.wbData = pcPlus4;
                outData.taken  = 1'b1;
                outData.nextPc = addrSum & ~cpuPkg::word'(1);
            end
            cpuPkg::opBeq, cpuPkg::opBne, cpuPkg::opBlt,
            cpuPkg::opBge, cpuPkg::opBltu, cpuPkg::opBgeu: begin
                outData.taken  = brTaken;
                outData.nextPc = brTaken ? pcImm : pcPlus4;
            end
            cpuPkg::opLb, cpuPkg::opLh, cpuPkg::opLw,
            cpuPkg::opLbu, cpuPkg::opLhu: begin
                outData.memAddr = addrSum; // Load data returns outside this slice
            end
            cpuPkg::opSb, cpuPkg::opSh, cpuPkg::opSw: begin
                outData.memAddr   = addrSum;
                outData.storeData = rs2Val;
            end
            default: begin
                outData.wbEn   = isAlu;
                outData.wbData = aluRes;
            end
        endcase
    end

endmodule

// ==== exec/regFile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuPkg::regIdx          rdIdxA,
    input  cpuPkg::regIdx          rdIdxB,
    output logic [`DATA_WIDTH-1:0] rdDataA,
    output logic [`DATA_WIDTH-1:0] rdDataB,
    input  logic                   wrEn,
    input  cpuPkg::regIdx          wrIdx,
    input  logic [`DATA_WIDTH-1:0] wrData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

    // x0 reads as zero
    assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

// ==== hw/decodeExecTop.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module decodeExecTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  cpuPkg::instRec   inData,
    output logic             inReady,
    output logic             outValid,
    output cpuPkg::commitRec outData,
    input  logic             outReady
);

    logic             headValid;
    cpuPkg::instRec   headData;
    logic             headReady;
    logic             resValid;
    cpuPkg::commitRec resData;
    logic             resReady;

    streamFifo #(
        .payloadT (cpuPkg::instRec),
        .DEPTH    (`QUEUE_DEPTH)
    ) inQueue (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inData   (inData),
        .inReady  (inReady),
        .outValid (headValid),
        .outData  (headData),
        .outReady (headReady)
    );

    execUnit exec0 (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (headValid),
        .inData   (headData),
        .inReady  (headReady),
        .outValid (resValid),
        .outData  (resData),
        .outReady (resReady)
    );

    streamFifo #(
        .payloadT (cpuPkg::commitRec),
        .DEPTH    (`QUEUE_DEPTH)
    ) outQueue (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (resValid),
        .inData   (resData),
        .inReady  (resReady),
        .outValid (outValid),
        .outData  (outData),
        .outReady (outReady)
    );

endmodule

// ==== hw/streamFifo.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module streamFifo #(
    parameter type payloadT = logic [31:0],
    parameter int  DEPTH    = `QUEUE_DEPTH
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData,
    input  logic    outReady
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          mem [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W:0]   wrSum;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Tail slot is head plus occupancy modulo depth
    always_comb begin
        wrSum = {1'b0, rdPtr} + (PTR_W + 1)'(count);
        if (wrSum >= (PTR_W + 1)'(DEPTH)) begin
            wrSum = wrSum - (PTR_W + 1)'(DEPTH);
        end
        wrPtr = wrSum[PTR_W-1:0];
    end

    assign outValid = (count != '0);
    assign inReady  = (count != CNT_W'(DEPTH)) || outReady; // Full but draining
    assign outData  = mem[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // Even duty cycle
    end

endmodule

// ==== tb/decodeExecTb.sv ====
`timescale 1ns/1ps

module decodeExecTb;

    localparam int MAX_VEC   = 64;
    localparam int CLK_NS    = 8;
    localparam int RESET_CYC = 4;

    logic             clk;
    logic             rstN;
    logic             inValid;
    cpuPkg::instRec   inData;
    logic             inReady;
    logic             outValid;
    cpuPkg::commitRec outData;
    logic             outReady;

    cpuPkg::instRec   stim [MAX_VEC];
    cpuPkg::commitRec expRec [MAX_VEC];
    int               nVec       = 0;
    int               sentCount  = 0;
    int               recvCount  = 0;
    int               errors     = 0;
    int               mismatches = 0;
    int               seed       = 79794;
    logic             loaded     = 1'b0;

    clockGen #(.PERIOD(CLK_NS)) clk0 (.clk(clk));

    decodeExecTop dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inData   (inData),
        .inReady  (inReady),
        .outValid (outValid),
        .outData  (outData),
        .outReady (outReady)
    );

    task automatic loadVectors();
        int             fd;
        int             got;
        logic [8*160:1] line;
        logic [31:0]    pc;
        logic [31:0]    inst;
        logic [31:0]    wbData;
        logic [31:0]    nextPc;
        logic [31:0]    memAddr;
        logic [31:0]    storeData;
        int             op;
        int             rd;
        int             wbEn;
        int             taken;
        fd = $fopen("tb/decodeVectors.txt", "r");
        if (fd != 0) begin
            void'($fgets(line, fd)); // Column header
            void'($fgets(line, fd));
            got = $fscanf(fd, "%h %h %d %d %d %h %h %h %h %d\n", pc, inst, op, rd, wbEn,
                          wbData, nextPc, memAddr, storeData, taken);
            while (got == 10 && nVec < MAX_VEC) begin
                stim[nVec] = '{pc: pc, inst: inst};
                expRec[nVec] = '{pc: pc, op: cpuPkg::opEnum'(op), rd: cpuPkg::regIdx'(rd),
                                 wbEn: wbEn[0], wbData: wbData, nextPc: nextPc,
                                 memAddr: memAddr, storeData: storeData, taken: taken[0]};
                nVec++;
                got = $fscanf(fd, "%h %h %d %d %d %h %h %h %h %d\n", pc, inst, op, rd, wbEn,
                              wbData, nextPc, memAddr, storeData, taken);
            end
            $fclose(fd);
        end
        assert (nVec > 0) else begin
            $display("No vectors could be read from tb/decodeVectors.txt");
            errors++;
        end
    endtask

    task automatic checkField(input int idx, input string name, input logic [31:0] got,
                              input logic [31:0] exp, inout logic bad);
        assert (got == exp) else begin
            $display("** Error at %0t: record %0d field %s got %h expected %h",
                     $time, idx, name, got, exp);
            errors++;
            bad = 1'b1;
        end
    endtask

    task automatic compareRecord(input cpuPkg::commitRec got, input int idx);
        cpuPkg::commitRec exp;
        logic             bad;
        exp = expRec[idx];
        bad = 1'b0;
        checkField(idx, "pc", got.pc, exp.pc, bad);
        checkField(idx, "op", 32'(got.op), 32'(exp.op), bad);
        checkField(idx, "rd", 32'(got.rd), 32'(exp.rd), bad);
        checkField(idx, "wbEn", 32'(got.wbEn), 32'(exp.wbEn), bad);
        checkField(idx, "wbData", got.wbData, exp.wbData, bad);
        checkField(idx, "nextPc", got.nextPc, exp.nextPc, bad);
        checkField(idx, "memAddr", got.memAddr, exp.memAddr, bad);
        checkField(idx, "storeData", got.storeData, exp.storeData, bad);
        checkField(idx, "taken", 32'(got.taken), 32'(exp.taken), bad);
        if (bad) begin
            mismatches++;
        end
    endtask

    // Handshakes complete on the rising edge
    always @(posedge clk) begin
        if (rstN && inValid && inReady) begin
            sentCount <= sentCount + 1;
        end
        if (rstN && outValid && outReady) begin
            assert (recvCount < nVec) else begin
                $display("Unexpected extra output record beyond the %0d expected", nVec);
                errors++;
            end
            if (recvCount < nVec) begin
                compareRecord(outData, recvCount);
            end
            recvCount <= recvCount + 1;
        end
    end

    initial begin : mainFlow
        rstN     = 1'b0;
        inValid  = 1'b0;
        inData   = '0;
        outReady = 1'b0;
        loadVectors();
        loaded = 1'b1;
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        assert (inReady && !outValid) else begin
            $display("DUT not idle after reset: inReady low or outValid high");
            errors++;
        end
        while (recvCount < nVec) begin
            outReady = ((($random(seed) & 32'h7fffffff) % 10) < 7); // About 70% ready
            if (sentCount < nVec) begin
                inValid = 1'b1;
                inData  = stim[sentCount];
            end else begin
                inValid = 1'b0;
            end
            @(negedge clk);
        end
        inValid  = 1'b0;
        outReady = 1'b1;
        repeat (8) @(negedge clk); // Drain window for stray records
        assert (recvCount == nVec) else begin
            $display("Received %0d output records but expected %0d", recvCount, nVec);
            errors++;
        end
        $display("Errors: %0d, mismatched records: %0d, records: %0d of %0d",
                 errors, mismatches, recvCount, nVec);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #(20 * nVec * CLK_NS + RESET_CYC * CLK_NS);
        $display("Timeout: only %0d of %0d output records arrived in time", recvCount, nVec);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== tb/decodeVectors.txt ====
// pc inst | expected: op(dec) rd(dec) wbEn(dec) wbData nextPc memAddr storeData taken(dec)
// hex words except where marked dec; one instruction per line, in commit order
00000000 00500093 19 1 1 00000005 00000004 00000000 00000000 0
00000004 FFD00113 19 2 1 FFFFFFFD 00000008 00000000 00000000 0
00000008 123451B7 1 3 1 12345000 0000000C 00000000 00000000 0
0000000C 00001217 2 4 1 0000100C 00000010 00000000 00000000 0
00000010 002082B3 28 5 1 00000002 00000014 00000000 00000000 0
00000014 40208333 29 6 1 00000008 00000018 00000000 00000000 0
00000018 001123B3 31 7 1 00000001 0000001C 00000000 00000000 0
0000001C 00113433 32 8 1 00000000 00000020 00000000 00000000 0
00000020 0041C4B3 33 9 1 1234400C 00000024 00000000 00000000 0
00000024 0060E533 36 10 1 0000000D 00000028 00000000 00000000 0
00000028 00A175B3 37 11 1 0000000D 0000002C 00000000 00000000 0
0000002C 00411613 25 12 1 FFFFFFD0 00000030 00000000 00000000 0
00000030 01C15693 26 13 1 0000000F 00000034 00000000 00000000 0
00000034 40115713 27 14 1 FFFFFFFE 00000038 00000000 00000000 0
00000038 00C097B3 30 15 1 00050000 0000003C 00000000 00000000 0
0000003C 00615833 34 16 1 00FFFFFF 00000040 00000000 00000000 0
00000040 401658B3 35 17 1 FFFFFFFE 00000044 00000000 00000000 0
00000044 00108863 5 0 0 00000000 00000054 00000000 00000000 1
00000048 00208863 5 0 0 00000000 0000004C 00000000 00000000 0
0000004C 00209863 6 0 0 00000000 0000005C 00000000 00000000 1
00000050 00109863 6 0 0 00000000 00000054 00000000 00000000 0
00000054 00114863 7 0 0 00000000 00000064 00000000 00000000 1
00000058 0020C863 7 0 0 00000000 0000005C 00000000 00000000 0
0000005C 0020D863 8 0 0 00000000 0000006C 00000000 00000000 1
00000060 00115863 8 0 0 00000000 00000064 00000000 00000000 0
00000064 FE20ECE3 9 0 0 00000000 0000005C 00000000 00000000 1
00000068 00116863 9 0 0 00000000 0000006C 00000000 00000000 0
0000006C 00117863 10 0 0 00000000 0000007C 00000000 00000000 1
00000070 0020F863 10 0 0 00000000 00000074 00000000 00000000 0
00000074 1000096F 3 18 1 00000078 00000174 00000000 00000000 1
00000078 010109E7 4 19 1 0000007C 0000000C 00000000 00000000 1
0000007C FFDFF06F 3 0 1 00000080 00000078 00000000 00000000 1
00000080 00190067 4 0 1 00000084 00000078 00000000 00000000 1
00000084 00100A33 28 20 1 00000005 00000088 00000000 00000000 0
00000088 FFC1AA83 13 21 0 00000000 0000008C 12344FFC 00000000 0
0000008C 0080CB03 14 22 0 00000000 00000090 0000000D 00000000 0
00000090 009081A3 16 0 0 00000000 00000094 00000008 1234400C 0
00000094 FEC31F23 17 0 0 00000000 00000098 00000006 FFFFFFD0 0
00000098 0232A023 18 0 0 00000000 0000009C 00000022 12345000 0
0000009C 0000000B 0 0 0 00000000 000000A0 00000000 00000000 0
000000A0 016A8BB3 28 23 1 00000000 000000A4 00000000 00000000 0
000000A4 00098C13 19 24 1 0000007C 000000A8 00000000 00000000 0
000000A8 FFF0BC93 21 25 1 00000001 000000AC 00000000 00000000 0
000000AC FFF14D13 22 26 1 00000002 000000B0 00000000 00000000 0
000000B0 FFC12D93 20 27 1 00000000 000000B4 00000000 00000000 0

// ==== vlog.f ====
+incdir+common
common/cpuPkg.sv
hw/streamFifo.sv
exec/decoder.sv
exec/regFile.sv
exec/execUnit.sv
hw/decodeExecTop.sv
tb/clockGen.sv
tb/decodeExecTb.sv
